/* common/fsqrt_params.svh */
// Field widths, recurrence sizing and fixed encodings for the
// single-precision square root unit
`ifndef FSQRT_PARAMS_SVH
`define FSQRT_PARAMS_SVH

// ==================================================
// IEEE 754 binary32 fields
// ==================================================
`define FSQRT_EXP_BITS 8
`define FSQRT_FRAC_BITS 23
// Fraction plus hidden bit
`define FSQRT_MANT_BITS 24
`define FSQRT_EXP_BIAS 127

// ==================================================
// Digit recurrence sizing
// ==================================================
// 24 mantissa bits, guard and two extra bits
`define FSQRT_ROOT_BITS 27
// Two radicand bits consumed per root bit
`define FSQRT_RAD_BITS 54
// Widened remainder, two bits above the radicand
`define FSQRT_REM_BITS 56
// Signed exponent with headroom for bias arithmetic
`define FSQRT_EXP_EXT_BITS 10
// Counts 0 to 26
`define FSQRT_ITER_BITS 5

// Fixed result encodings
`define FSQRT_CANON_NAN 32'h7FC00000
`define FSQRT_POS_INF 32'h7F800000

`endif

/* common/fsqrt_pkg.sv */
// Shared typedefs for the square root unit, with rounding-mode codes,
// flag bit positions and the control FSM state encoding
`include "fsqrt_params.svh"

package fsqrt_pkg;

  // ==================================================
  // Datapath vector types
  // ==================================================
  typedef logic [31:0] fp32_t;
  typedef logic [`FSQRT_FRAC_BITS-1:0] frac_t;
  typedef logic [`FSQRT_MANT_BITS-1:0] mant_t;
  // Signed so the halving shift stays arithmetic
  typedef logic signed [`FSQRT_EXP_EXT_BITS-1:0] exp_ext_t;
  typedef logic [`FSQRT_ROOT_BITS-1:0] root_t;
  typedef logic [`FSQRT_REM_BITS-1:0] rem_t;
  typedef logic [`FSQRT_RAD_BITS-1:0] rad_t;
  typedef logic [2:0] rm_t;
  // NV DZ OF UF NX, bit 4 down to bit 0
  typedef logic [4:0] flags_t;

  // RISC-V frm encodings
  localparam rm_t RM_RNE = 3'd0;
  localparam rm_t RM_RTZ = 3'd1;
  localparam rm_t RM_RDN = 3'd2;
  localparam rm_t RM_RUP = 3'd3;
  localparam rm_t RM_RMM = 3'd4;

  // Flag positions inside flags_t
  localparam int FLAG_NV = 4;
  localparam int FLAG_NX = 0;

  // ==================================================
  // Sequencer states
  // ==================================================
  typedef enum logic [2:0] {
    IDLE,
    SETUP,
    INIT,
    COMPUTE,
    NORMALIZE,
    ROUND,
    DONE
  } fsqrt_state_t;

endpackage

/* design/fsqrt_unpack.sv */
// Operand unpack and classify, subnormal normalize, special-case select,
// radicand alignment and halved exponent
`timescale 1ns/100ps
`include "fsqrt_params.svh"

module fsqrt_unpack (
  input  fsqrt_pkg::fp32_t    i_operand,
  output logic                o_is_special,
  output fsqrt_pkg::fp32_t    o_special_result,
  output logic                o_special_nv,
  output fsqrt_pkg::rad_t     o_radicand,
  output fsqrt_pkg::exp_ext_t o_half_exp
);

  localparam int LzcBits = $clog2(`FSQRT_FRAC_BITS + 1);

  logic                          sign;
  logic [`FSQRT_EXP_BITS-1:0]    exp;
  fsqrt_pkg::frac_t              frac;
  logic                          is_zero;
  logic                          is_sub;
  logic                          is_inf;
  logic                          is_nan;
  logic                          is_snan;
  logic [LzcBits-1:0]            lzc;
  fsqrt_pkg::mant_t              mant_norm;
  fsqrt_pkg::exp_ext_t           exp_adj;
  fsqrt_pkg::exp_ext_t           exp_unb;
  fsqrt_pkg::exp_ext_t           exp_sum;
  logic [`FSQRT_MANT_BITS:0]     mant_int;

  // ==================================================
  // Field split and classification
  // ==================================================
  assign sign = i_operand[31];
  assign exp  = i_operand[30 -: `FSQRT_EXP_BITS];
  assign frac = i_operand[`FSQRT_FRAC_BITS-1:0];

  assign is_zero = (exp == '0) && (frac == '0);
  assign is_sub  = (exp == '0) && (frac != '0);
  assign is_inf  = (exp == '1) && (frac == '0);
  assign is_nan  = (exp == '1) && (frac != '0);
  // Quiet bit clear marks a signaling NaN
  assign is_snan = is_nan && !frac[`FSQRT_FRAC_BITS-1];

  // Leading-zero count of the fraction, first set bit from the top wins
  always_comb begin
    lzc = LzcBits'(`FSQRT_FRAC_BITS);
    for (int i = 0; i < `FSQRT_FRAC_BITS; i++) begin
      if (frac[i]) begin
        lzc = LzcBits'(`FSQRT_FRAC_BITS - 1 - i);
      end
    end
  end

  // ==================================================
  // Mantissa normalize and exponent prep
  // ==================================================
  always_comb begin
    if (is_sub) begin
      // Shift leading one into the hidden position, biased exp becomes -lzc
      mant_norm = mant_t_shift(frac, lzc);
      exp_adj   = fsqrt_pkg::exp_ext_t'(0) - fsqrt_pkg::exp_ext_t'(lzc);
    end else begin
      mant_norm = {1'b1, frac};
      exp_adj   = fsqrt_pkg::exp_ext_t'(exp);
    end

    exp_unb = exp_adj - fsqrt_pkg::exp_ext_t'(`FSQRT_EXP_BIAS);

    // Odd unbiased exponent: double the mantissa so the root exponent halves cleanly
    if (exp_unb[0]) begin
      mant_int = {mant_norm, 1'b0};
      exp_sum  = exp_adj + fsqrt_pkg::exp_ext_t'(`FSQRT_EXP_BIAS - 1);
    end else begin
      mant_int = {1'b0, mant_norm};
      exp_sum  = exp_adj + fsqrt_pkg::exp_ext_t'(`FSQRT_EXP_BIAS);
    end
  end

  function automatic fsqrt_pkg::mant_t mant_t_shift(input fsqrt_pkg::frac_t f,
                                                    input logic [LzcBits-1:0] n);
    fsqrt_pkg::mant_t wide;
    wide = {1'b0, f};
    return wide << (n + 1'b1);
  endfunction

  // Integer pair of the radicand lands on the top two bits
  assign o_radicand = fsqrt_pkg::rad_t'(mant_int) << (`FSQRT_RAD_BITS - `FSQRT_MANT_BITS - 1);
  assign o_half_exp = exp_sum >>> 1;

  // ==================================================
  // Special results
  // ==================================================
  always_comb begin
    o_is_special     = 1'b1;
    o_special_result = `FSQRT_CANON_NAN;
    o_special_nv     = 1'b0;
    if (is_nan) begin
      // Quiet NaN passes silently, signaling NaN raises NV
      o_special_nv = is_snan;
    end else if (sign && !is_zero) begin
      o_special_nv = 1'b1;
    end else if (is_inf) begin
      o_special_result = `FSQRT_POS_INF;
    end else if (is_zero) begin
      // Signed zero returns itself
      o_special_result = {sign, 31'b0};
    end else begin
      o_is_special = 1'b0;
    end
  end

endmodule

/* fsqrt_core/fsqrt_recurrence.sv */
// Bit-serial square root recurrence holding root, remainder,
// radicand and exponent, with a one-step normalize
`timescale 1ns/100ps
`include "fsqrt_params.svh"

module fsqrt_recurrence (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  input  logic                i_step,
  input  logic                i_norm,
  input  fsqrt_pkg::rad_t     i_radicand,
  input  fsqrt_pkg::exp_ext_t i_exp,
  output fsqrt_pkg::root_t    o_root,
  output logic                o_sticky,
  output fsqrt_pkg::exp_ext_t o_exp
);

  fsqrt_pkg::root_t    root_q;
  fsqrt_pkg::rem_t     rem_q;
  fsqrt_pkg::rad_t     rad_q;
  fsqrt_pkg::exp_ext_t exp_q;

  fsqrt_pkg::rem_t     rem_cand;
  fsqrt_pkg::rem_t     trial;
  logic                rem_ge;

  // ==================================================
  // One root bit per step
  // ==================================================
  // Bring down the next radicand pair below the remainder
  assign rem_cand = {rem_q[`FSQRT_REM_BITS-3:0], rad_q[`FSQRT_RAD_BITS-1 -: 2]};

  // Trial divisor is 4*root + 1
  assign trial = {{(`FSQRT_REM_BITS - `FSQRT_ROOT_BITS - 2){1'b0}}, root_q, 2'b01};

  assign rem_ge = (rem_cand >= trial);

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      // Fresh operand, partial results cleared
      root_q <= '0;
      rem_q  <= '0;
      rad_q  <= i_radicand;
      exp_q  <= i_exp;
    end else if (i_step) begin
      rad_q <= {rad_q[`FSQRT_RAD_BITS-3:0], 2'b00};
      if (rem_ge) begin
        rem_q  <= rem_cand - trial;
        root_q <= {root_q[`FSQRT_ROOT_BITS-2:0], 1'b1};
      end else begin
        rem_q  <= rem_cand;
        root_q <= {root_q[`FSQRT_ROOT_BITS-2:0], 1'b0};
      end
    end else if (i_norm) begin
      // Radicand in [1,4) keeps the top bit set, this only guards the
      // hidden-bit position
      if (!root_q[`FSQRT_ROOT_BITS-1]) begin
        root_q <= root_q << 1;
        exp_q  <= exp_q - fsqrt_pkg::exp_ext_t'(1);
      end
    end
  end

  // ==================================================
  // Outputs to rounding
  // ==================================================
  assign o_root   = root_q;
  // Any remainder left means the root is inexact
  assign o_sticky = |rem_q;
  assign o_exp    = exp_q;

  // Loading a new operand mid-iteration would corrupt the root in flight
  a_no_start_during_step: assert property (
    @(posedge i_clk) disable iff (i_rst)
    !(i_step && i_start)
  );

endmodule

/* design/fsqrt_round.sv */
// Guard and sticky extraction, per-mode round-up decision,
// result packing and exception flags
`timescale 1ns/100ps
`include "fsqrt_params.svh"

module fsqrt_round (
  input  fsqrt_pkg::root_t    i_root,
  input  logic                i_sticky,
  input  fsqrt_pkg::exp_ext_t i_exp,
  input  fsqrt_pkg::rm_t      i_rm,
  output fsqrt_pkg::fp32_t    o_result,
  output fsqrt_pkg::flags_t   o_flags
);

  fsqrt_pkg::mant_t          mant;
  logic                      guard;
  logic                      sticky;
  logic                      lsb;
  logic                      rne_up;
  logic                      round_up;
  logic [`FSQRT_MANT_BITS:0] rounded;
  logic                      carry;
  fsqrt_pkg::exp_ext_t       exp_out;
  fsqrt_pkg::frac_t          frac_out;

  // ==================================================
  // Bit extraction
  // ==================================================
  // Top 24 bits are the mantissa with the hidden one
  assign mant  = i_root[`FSQRT_ROOT_BITS-1 -: `FSQRT_MANT_BITS];
  assign guard = i_root[`FSQRT_ROOT_BITS-`FSQRT_MANT_BITS-1];
  // Low root bits fold in with the leftover remainder
  assign sticky = (|i_root[`FSQRT_ROOT_BITS-`FSQRT_MANT_BITS-2:0]) | i_sticky;
  assign lsb    = mant[0];

  // Ties to even
  assign rne_up = guard & (sticky | lsb);

  // ==================================================
  // Round-up decision, result is never negative
  // ==================================================
  always_comb begin
    case (i_rm)
      fsqrt_pkg::RM_RNE: round_up = rne_up;
      // Toward zero and toward -inf both truncate a positive value
      fsqrt_pkg::RM_RTZ,
      fsqrt_pkg::RM_RDN: round_up = 1'b0;
      fsqrt_pkg::RM_RUP: round_up = guard | sticky;
      fsqrt_pkg::RM_RMM: round_up = guard;
      // Reserved frm codes fall back to RNE
      default: round_up = rne_up;
    endcase
  end

  // ==================================================
  // Increment and pack
  // ==================================================
  assign rounded = {1'b0, mant} + {{`FSQRT_MANT_BITS{1'b0}}, round_up};
  assign carry   = rounded[`FSQRT_MANT_BITS];

  always_comb begin
    if (carry) begin
      // Mantissa wrapped to 10.000..., renormalize into the next binade
      exp_out  = i_exp + fsqrt_pkg::exp_ext_t'(1);
      frac_out = rounded[`FSQRT_MANT_BITS-1:1];
    end else begin
      exp_out  = i_exp;
      frac_out = rounded[`FSQRT_FRAC_BITS-1:0];
    end
  end

  assign o_result = {1'b0, exp_out[`FSQRT_EXP_BITS-1:0], frac_out};

  // Only NX can come out of an ordinary root
  always_comb begin
    o_flags = '0;
    o_flags[fsqrt_pkg::FLAG_NX] = guard | sticky;
  end

endmodule

/* design/fsqrt_top.sv */
// Square root top level with the sequencing FSM, stall and valid
// handshake, operand capture and result registers
`timescale 1ns/100ps
`include "fsqrt_params.svh"

module fsqrt_top (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_valid,
  input  fsqrt_pkg::fp32_t  i_operand,
  input  fsqrt_pkg::rm_t    i_rounding_mode,
  output fsqrt_pkg::fp32_t  o_result,
  output fsqrt_pkg::flags_t o_flags,
  output logic              o_valid,
  output logic              o_stall
);

  fsqrt_pkg::fsqrt_state_t     state_q;
  fsqrt_pkg::fsqrt_state_t     state_d;
  logic [`FSQRT_ITER_BITS-1:0] iter_q;

  // Captured request
  fsqrt_pkg::fp32_t    operand_q;
  fsqrt_pkg::rm_t      rm_q;

  // Unpack outputs and their SETUP copies
  logic                is_special;
  fsqrt_pkg::fp32_t    special_result;
  logic                special_nv;
  fsqrt_pkg::rad_t     radicand;
  fsqrt_pkg::exp_ext_t half_exp;
  logic                spec_q;
  fsqrt_pkg::fp32_t    spec_result_q;
  logic                spec_nv_q;
  fsqrt_pkg::rad_t     radicand_q;
  fsqrt_pkg::exp_ext_t half_exp_q;
  fsqrt_pkg::flags_t   spec_flags;

  // Recurrence and rounding
  logic                start;
  logic                step;
  logic                norm;
  fsqrt_pkg::root_t    root;
  logic                sticky;
  fsqrt_pkg::exp_ext_t root_exp;
  fsqrt_pkg::fp32_t    round_result;
  fsqrt_pkg::flags_t   round_flags;

  fsqrt_pkg::fp32_t    result_q;
  fsqrt_pkg::flags_t   flags_q;
  logic                valid_q;

  fsqrt_unpack u_unpack (
    .i_operand        (operand_q),
    .o_is_special     (is_special),
    .o_special_result (special_result),
    .o_special_nv     (special_nv),
    .o_radicand       (radicand),
    .o_half_exp       (half_exp)
  );

  fsqrt_recurrence u_recurrence (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_start    (start),
    .i_step     (step),
    .i_norm     (norm),
    .i_radicand (radicand_q),
    .i_exp      (half_exp_q),
    .o_root     (root),
    .o_sticky   (sticky),
    .o_exp      (root_exp)
  );

  fsqrt_round u_round (
    .i_root   (root),
    .i_sticky (sticky),
    .i_exp    (root_exp),
    .i_rm     (rm_q),
    .o_result (round_result),
    .o_flags  (round_flags)
  );

  // ==================================================
  // Sequencer
  // ==================================================
  assign start = (state_q == fsqrt_pkg::INIT) && !spec_q;
  assign step  = (state_q == fsqrt_pkg::COMPUTE);
  assign norm  = (state_q == fsqrt_pkg::NORMALIZE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      fsqrt_pkg::IDLE:      if (i_valid) state_d = fsqrt_pkg::SETUP;
      fsqrt_pkg::SETUP:     state_d = fsqrt_pkg::INIT;
      // Special operands skip the recurrence entirely
      fsqrt_pkg::INIT:      state_d = spec_q ? fsqrt_pkg::DONE : fsqrt_pkg::COMPUTE;
      fsqrt_pkg::COMPUTE: begin
        if (iter_q == `FSQRT_ITER_BITS'(`FSQRT_ROOT_BITS - 1)) begin
          state_d = fsqrt_pkg::NORMALIZE;
        end
      end
      fsqrt_pkg::NORMALIZE: state_d = fsqrt_pkg::ROUND;
      fsqrt_pkg::ROUND:     state_d = fsqrt_pkg::DONE;
      fsqrt_pkg::DONE:      state_d = fsqrt_pkg::IDLE;
      default:              state_d = fsqrt_pkg::IDLE;
    endcase
  end

  always_comb begin
    spec_flags = '0;
    spec_flags[fsqrt_pkg::FLAG_NV] = spec_nv_q;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q  <= fsqrt_pkg::IDLE;
      iter_q   <= '0;
      spec_q   <= 1'b0;
      result_q <= '0;
      flags_q  <= '0;
      valid_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_q <= (state_q == fsqrt_pkg::DONE);
      if (state_q == fsqrt_pkg::SETUP) spec_q <= is_special;
      if (state_q == fsqrt_pkg::INIT) begin
        iter_q <= '0;
        if (spec_q) begin
          result_q <= spec_result_q;
          flags_q  <= spec_flags;
        end
      end
      if (step) iter_q <= iter_q + 1'b1;
      if (state_q == fsqrt_pkg::ROUND) begin
        result_q <= round_result;
        flags_q  <= round_flags;
      end
    end
  end

  // Operand and setup captures
  always_ff @(posedge i_clk) begin
    if (state_q == fsqrt_pkg::IDLE && i_valid) begin
      operand_q <= i_operand;
      rm_q      <= i_rounding_mode;
    end
    if (state_q == fsqrt_pkg::SETUP) begin
      spec_result_q <= special_result;
      spec_nv_q     <= special_nv;
      radicand_q    <= radicand;
      half_exp_q    <= half_exp;
    end
  end

  // ==================================================
  // Handshake outputs
  // ==================================================
  assign o_result = result_q;
  assign o_flags  = flags_q;
  assign o_valid  = valid_q;
  // Stall from the request cycle until the result pulse
  assign o_stall  = (i_valid || (state_q != fsqrt_pkg::IDLE)) && !valid_q;

  a_valid_one_cycle: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_valid |=> !o_valid
  );

  a_no_stall_when_idle: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (state_q == fsqrt_pkg::IDLE && !i_valid) |-> !o_stall
  );

endmodule

/* dv/fsqrt_checker.sv */
// Testbench checker watching the square root unit ports, with the latency,
// stall and result comparison against the expected row, and pass and fail counts
`timescale 1ns/100ps

module fsqrt_checker (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_valid,
  input  fsqrt_pkg::fp32_t  i_operand,
  input  fsqrt_pkg::rm_t    i_rounding_mode,
  input  fsqrt_pkg::fp32_t  i_result,
  input  fsqrt_pkg::flags_t i_flags,
  input  logic              i_dut_valid,
  input  logic              i_stall,
  input  logic [7:0]        i_test_id,
  input  fsqrt_pkg::fp32_t  i_exp_result,
  input  fsqrt_pkg::flags_t i_exp_flags,
  input  logic              i_exp_special,
  output int                o_pass_count,
  output int                o_fail_count,
  output int                o_error_count
);

  // Edges from acceptance to the edge that raises o_valid
  localparam int SpecialLatency = 3;
  localparam int NormalLatency  = 32;

  logic              busy = 1'b0;
  logic              was_reset = 1'b0;
  logic              mismatch;
  logic              test_bad;
  int                edge_cnt = 0;
  int                latency = 0;
  int                pass_cnt = 0;
  int                fail_cnt = 0;
  int                err_cnt = 0;

  // Row captured when its operand is accepted
  fsqrt_pkg::fp32_t  op_q;
  fsqrt_pkg::rm_t    rm_q;
  fsqrt_pkg::fp32_t  res_q;
  fsqrt_pkg::flags_t flags_q;
  logic [7:0]        id_q;

  task automatic compare_value(input string name, input logic [31:0] expv,
                               input logic [31:0] got);
    if (got !== expv) begin
      $display("ERROR t=%0t %s expected 0x%0h got 0x%0h", $time, name, expv, got);
      mismatch = 1'b1;
    end
  endtask

  // ==================================================
  // Sampling at the rising edge, so values are the ones just before it
  // ==================================================
  always @(posedge i_clk) begin
    mismatch = 1'b0;
    if (i_rst) begin
      busy      = 1'b0;
      was_reset = 1'b1;
    end else begin
      // First cycle out of reset, result registers cleared
      if (was_reset) begin
        compare_value("o_result", 32'h0, i_result);
        compare_value("o_flags", 32'h0, 32'(i_flags));
        was_reset = 1'b0;
      end
      if (busy && edge_cnt == latency) begin
        // Result cycle of the operation in flight
        if (i_dut_valid !== 1'b1) begin
          $display("o_valid missing for test %0d at t=%0t, expected %0d edges after acceptance",
                   id_q, $time, latency);
          mismatch = 1'b1;
        end
        compare_value("o_stall", 32'h0, 32'(i_stall));
        compare_value("o_result", res_q, i_result);
        compare_value("o_flags", 32'(flags_q), 32'(i_flags));
        test_bad = test_bad | mismatch;
        if (test_bad) begin
          $display("FAIL test %0d: operand 0x%08h rm %0d result 0x%08h flags 0x%02h",
                   id_q, op_q, rm_q, i_result, i_flags);
          fail_cnt = fail_cnt + 1;
        end else begin
          $display("PASS test %0d: operand 0x%08h rm %0d result 0x%08h flags 0x%02h",
                   id_q, op_q, rm_q, i_result, i_flags);
          pass_cnt = pass_cnt + 1;
        end
        busy = 1'b0;
      end else if (busy) begin
        if (i_dut_valid !== 1'b0) begin
          $display("o_valid arrived early for test %0d at t=%0t", id_q, $time);
          mismatch = 1'b1;
        end
        // Held for the whole busy window, stray requests included
        compare_value("o_stall", 32'h1, 32'(i_stall));
        test_bad = test_bad | mismatch;
        edge_cnt = edge_cnt + 1;
      end else begin
        if (i_dut_valid !== 1'b0) begin
          $display("Extra o_valid pulse at t=%0t with no operation in flight", $time);
          mismatch = 1'b1;
        end
        // Idle, stall just follows the request strobe
        compare_value("o_stall", 32'(i_valid), 32'(i_stall));
        if (mismatch) begin
          err_cnt = err_cnt + 1;
        end
      end
      // Acceptance, also on the edge that ends o_valid
      if (!busy && i_valid) begin
        busy     = 1'b1;
        edge_cnt = 0;
        test_bad = 1'b0;
        latency  = i_exp_special ? SpecialLatency : NormalLatency;
        op_q     = i_operand;
        rm_q     = i_rounding_mode;
        res_q    = i_exp_result;
        flags_q  = i_exp_flags;
        id_q     = i_test_id;
      end
    end
  end

  assign o_pass_count  = pass_cnt;
  assign o_fail_count  = fail_cnt;
  assign o_error_count = err_cnt;

endmodule

/* dv/fsqrt_tb.sv */
// Testbench top for the square root unit with clock, reset, stimulus table,
// timeout and the closing summary
`timescale 1ns/100ps

module fsqrt_tb;

  localparam int NumRows   = 17;
  // Each row fits in 40 cycles with margin left for reset and drain
  localparam int MaxCycles = NumRows * 40 + 50;

  logic              clk;
  logic              rst;
  logic              valid;
  fsqrt_pkg::fp32_t  operand;
  fsqrt_pkg::rm_t    rm;
  fsqrt_pkg::fp32_t  o_result;
  fsqrt_pkg::flags_t o_flags;
  logic              o_valid;
  logic              o_stall;

  // Expected outcome of the row being presented
  fsqrt_pkg::fp32_t  exp_result;
  fsqrt_pkg::flags_t exp_flags;
  logic              exp_special;
  logic [7:0]        test_id;

  // ==================================================
  // Stimulus table
  // ==================================================
  fsqrt_pkg::fp32_t  tbl_operand [NumRows];
  fsqrt_pkg::rm_t    tbl_rm [NumRows];
  fsqrt_pkg::fp32_t  tbl_result [NumRows];
  fsqrt_pkg::flags_t tbl_flags [NumRows];
  // Latency class is 1 for special operands
  logic              tbl_special [NumRows];
  // Stray requests injected while busy
  logic              tbl_noise [NumRows];
  int                row_count = 0;
  int                cycle_count = 0;
  int                pass_count;
  int                fail_count;
  int                error_count;

  fsqrt_top dut (
    .i_clk           (clk),
    .i_rst           (rst),
    .i_valid         (valid),
    .i_operand       (operand),
    .i_rounding_mode (rm),
    .o_result        (o_result),
    .o_flags         (o_flags),
    .o_valid         (o_valid),
    .o_stall         (o_stall)
  );

  fsqrt_checker u_checker (
    .i_clk           (clk),
    .i_rst           (rst),
    .i_valid         (valid),
    .i_operand       (operand),
    .i_rounding_mode (rm),
    .i_result        (o_result),
    .i_flags         (o_flags),
    .i_dut_valid     (o_valid),
    .i_stall         (o_stall),
    .i_test_id       (test_id),
    .i_exp_result    (exp_result),
    .i_exp_flags     (exp_flags),
    .i_exp_special   (exp_special),
    .o_pass_count    (pass_count),
    .o_fail_count    (fail_count),
    .o_error_count   (error_count)
  );

  task automatic add_row(input fsqrt_pkg::fp32_t op, input fsqrt_pkg::rm_t mode,
                         input fsqrt_pkg::fp32_t res, input fsqrt_pkg::flags_t flg,
                         input logic special, input logic noise);
    tbl_operand[row_count] = op;
    tbl_rm[row_count]      = mode;
    tbl_result[row_count]  = res;
    tbl_flags[row_count]   = flg;
    tbl_special[row_count] = special;
    tbl_noise[row_count]   = noise;
    row_count = row_count + 1;
  endtask

  task automatic fill_table();
    // Exact roots of 4.0, subnormal 2^-128, 1.0 and 9.0
    add_row(32'h40800000, 3'd0, 32'h40000000, 5'h00, 1'b0, 1'b0);
    add_row(32'h00200000, 3'd0, 32'h1F800000, 5'h00, 1'b0, 1'b0);
    add_row(32'h3F800000, 3'd0, 32'h3F800000, 5'h00, 1'b0, 1'b0);
    add_row(32'h41100000, 3'd0, 32'h40400000, 5'h00, 1'b0, 1'b0);
    // sqrt(2) lies below the halfway point so only RUP rounds up
    add_row(32'h40000000, 3'd0, 32'h3FB504F3, 5'h01, 1'b0, 1'b1);
    add_row(32'h40000000, 3'd1, 32'h3FB504F3, 5'h01, 1'b0, 1'b0);
    add_row(32'h40000000, 3'd2, 32'h3FB504F3, 5'h01, 1'b0, 1'b0);
    add_row(32'h40000000, 3'd3, 32'h3FB504F4, 5'h01, 1'b0, 1'b1);
    add_row(32'h40000000, 3'd4, 32'h3FB504F3, 5'h01, 1'b0, 1'b0);
    // Reserved mode 5 behaves as RNE
    add_row(32'h40000000, 3'd5, 32'h3FB504F3, 5'h01, 1'b0, 1'b0);
    // Special operands qNaN, sNaN, -1.0, +inf, -0, +0 and -inf
    add_row(32'h7FC00000, 3'd0, 32'h7FC00000, 5'h00, 1'b1, 1'b0);
    add_row(32'h7F800001, 3'd0, 32'h7FC00000, 5'h10, 1'b1, 1'b0);
    add_row(32'hBF800000, 3'd0, 32'h7FC00000, 5'h10, 1'b1, 1'b0);
    add_row(32'h7F800000, 3'd0, 32'h7F800000, 5'h00, 1'b1, 1'b0);
    add_row(32'h80000000, 3'd0, 32'h80000000, 5'h00, 1'b1, 1'b0);
    add_row(32'h00000000, 3'd0, 32'h00000000, 5'h00, 1'b1, 1'b0);
    add_row(32'hFF800000, 3'd3, 32'h7FC00000, 5'h10, 1'b1, 1'b0);
  endtask

  // Present one row on the current falling edge and wait for its result
  task automatic apply_row(input int idx);
    valid       = 1'b1;
    operand     = tbl_operand[idx];
    rm          = tbl_rm[idx];
    exp_result  = tbl_result[idx];
    exp_flags   = tbl_flags[idx];
    exp_special = tbl_special[idx];
    test_id     = 8'(idx);
    @(negedge clk);
    valid = 1'b0;
    if (tbl_noise[idx]) begin
      // A mode that rounds sqrt(2) the other way must not reach the result in flight
      repeat (3) @(negedge clk);
      valid   = 1'b1;
      operand = 32'h4E6E6B28;
      rm      = (tbl_rm[idx] == fsqrt_pkg::RM_RUP) ? fsqrt_pkg::RM_RTZ : fsqrt_pkg::RM_RUP;
      @(negedge clk);
      valid = 1'b0;
    end
    while (!o_valid) @(negedge clk);
  endtask

  // ==================================================
  // Clock, timeout and main sequence
  // ==================================================
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MaxCycles) begin
      $display("Timeout after %0d cycles, the DUT stopped returning results", MaxCycles);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    rst         = 1'b1;
    valid       = 1'b0;
    operand     = '0;
    rm          = '0;
    exp_result  = '0;
    exp_flags   = '0;
    exp_special = 1'b0;
    test_id     = '0;
    fill_table();
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    // Next row goes out in the o_valid cycle and is accepted on the edge ending it
    for (int i = 0; i < NumRows; i++) begin
      apply_row(i);
    end
    repeat (3) @(negedge clk);
    $display("Summary: %0d of %0d tests passed, %0d failed, %0d other errors",
             pass_count, NumRows, fail_count, error_count);
    if (fail_count == 0 && error_count == 0 && pass_count == NumRows) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+common
common/fsqrt_pkg.sv
design/fsqrt_unpack.sv
fsqrt_core/fsqrt_recurrence.sv
design/fsqrt_round.sv
design/fsqrt_top.sv
dv/fsqrt_checker.sv
dv/fsqrt_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the square root testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module fsqrt_tb -f vlog.f -o fsqrt_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fsqrt_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi

echo "No failure found in $LOG"
exit 0
